//--- src/dbg_cfg.svh
// ****************************************
// Build constants of the debug access port
// All addresses are byte addresses and every access is one full word
// The SRAM window starts at address 0
// ****************************************
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Word and address widths
`define DBG_DATA_W         32
`define DBG_ADDR_W         32

// AHB SRAM geometry and timing
`define DBG_SRAM_WORDS     64
`define DBG_SRAM_WAIT      2

// APB system registers
`define DBG_SYS_REGS       8
`define DBG_SYS_ID         32'h0DB6_0001

// Cycles without an acknowledge before an access is abandoned
`define DBG_TIMEOUT_CYCLES 64

`endif

//--- src/dbg_pkg.sv
// ****************************************
// Shared types of the debug access port
// Command codes sit in the low bits of the command word
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

package dbg_pkg;

	// Command codes, unknown codes fall back to MEM_READ
	typedef enum logic [1:0] {
		MEM_READ  = 2'd0,
		MEM_WRITE = 2'd1,
		SYS_READ  = 2'd2,
		SYS_WRITE = 2'd3
	} cmd_t;

	// AHB transfer types in use
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10
	} htrans_t;

	// Only word transfers are issued
	typedef enum logic [2:0] {
		HSIZE_WORD = 3'b010
	} hsize_t;

	// Status word returned first in every response
	typedef struct packed {
		logic [`DBG_DATA_W-3:0] zero;
		logic                   timeout;
		logic                   error;
	} rsp_status_t;

endpackage

`default_nettype wire

//--- src/dbg_ahb_if.sv
// ****************************************
// AHB-Lite link, single master and single slave
// Word transfers only, no burst or protection signals
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

interface dbg_ahb_if;

	// Address phase and write data from the master
	dbg_pkg::htrans_t        htrans;
	logic [`DBG_ADDR_W-1:0]  haddr;
	logic                    hwrite;
	dbg_pkg::hsize_t         hsize;
	logic [`DBG_DATA_W-1:0]  hwdata;

	// Data phase answer from the slave
	logic [`DBG_DATA_W-1:0]  hrdata;
	logic                    hready;
	logic                    hresp;

	modport master
	(
		output htrans, haddr, hwrite, hsize, hwdata,
		input  hrdata, hready, hresp
	);

	modport slave
	(
		input  htrans, haddr, hwrite, hsize, hwdata,
		output hrdata, hready, hresp
	);

endinterface

`default_nettype wire

//--- src/dbg_apb_if.sv
// ****************************************
// APB link between the engine and the system registers
// One slave, so psel needs no decoding
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

interface dbg_apb_if;

	logic                    psel;
	logic                    penable;
	logic [`DBG_ADDR_W-1:0]  paddr;
	logic                    pwrite;
	logic [`DBG_DATA_W-1:0]  pwdata;

	logic [`DBG_DATA_W-1:0]  prdata;
	logic                    pready;
	logic                    pslverr;

	modport master
	(
		output psel, penable, paddr, pwrite, pwdata,
		input  prdata, pready, pslverr
	);

	modport slave
	(
		input  psel, penable, paddr, pwrite, pwdata,
		output prdata, pready, pslverr
	);

endinterface

`default_nettype wire

//--- src/dbg_cmd_engine.sv
// ****************************************
// Turns a command word stream into one AHB or APB access
// One command in flight, no new command until the response is taken
// Response is a status word, then a data word for reads
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_cmd_engine
(
	input  wire logic                   rvx_port_22,
	input  wire logic                   rvx_port_00,

	input  wire logic                   cmd_valid,
	input  wire logic [`DBG_DATA_W-1:0] cmd_data,
	output logic                        cmd_ready,

	output logic                        rsp_valid,
	output logic [`DBG_DATA_W-1:0]      rsp_data,
	input  wire logic                   rsp_ready,

	output logic                        busy,
	output logic                        restart,
	input  wire logic                   expired,

	dbg_ahb_if.master                   ahb,
	dbg_apb_if.master                   apb
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_ADDR,
		ST_WDATA,
		ST_AHB_REQ,
		ST_AHB_WAIT,
		ST_APB_SETUP,
		ST_APB_ACCESS,
		ST_RSP_STATUS,
		ST_RSP_DATA
	} state_t;

	state_t                 state;
	dbg_pkg::cmd_t          cmd_q;
	dbg_pkg::rsp_status_t   status_q;
	logic [`DBG_ADDR_W-1:0] addr_q;
	logic [`DBG_DATA_W-1:0] wdata_q;
	logic [`DBG_DATA_W-1:0] rdata_q;
	logic                   is_write;
	logic                   is_sys;
	logic                   bus_done;
	logic                   timed_out;

	// Codes with upper bits set are taken as MEM_READ
	function automatic dbg_pkg::cmd_t decode_cmd(input logic [`DBG_DATA_W-1:0] word);
		dbg_pkg::cmd_t code;
		if (word[`DBG_DATA_W-1:2] != '0)
			code = dbg_pkg::MEM_READ;
		else
			code = dbg_pkg::cmd_t'(word[1:0]);
		return code;
	endfunction

	function automatic dbg_pkg::rsp_status_t make_status(input logic err, input logic tmo);
		dbg_pkg::rsp_status_t st;
		st         = '0;
		st.error   = err;
		st.timeout = tmo;
		return st;
	endfunction

	always_comb
	begin
		is_write = 1'b0;
		is_sys   = 1'b0;
		case (cmd_q)
			dbg_pkg::MEM_WRITE: is_write = 1'b1;
			dbg_pkg::SYS_READ:  is_sys   = 1'b1;
			dbg_pkg::SYS_WRITE:
			begin
				is_write = 1'b1;
				is_sys   = 1'b1;
			end
			default: ;
		endcase
	end

	assign bus_done  = ((state == ST_AHB_WAIT) && ahb.hready) ||
	                   ((state == ST_APB_ACCESS) && apb.pready);
	// A real answer wins over a timeout in the same cycle
	assign timed_out = busy && expired && !bus_done;

	// ****************************************
	// Sequencer
	// ****************************************
	always_ff @(posedge rvx_port_22 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			state    <= ST_IDLE;
			cmd_q    <= dbg_pkg::MEM_READ;
			status_q <= '0;
		end
		else if (timed_out)
		begin
			state    <= ST_RSP_STATUS;
			status_q <= make_status(1'b1, 1'b1);
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (cmd_valid)
					begin
						cmd_q <= decode_cmd(cmd_data);
						state <= ST_ADDR;
					end
				ST_ADDR:
					if (cmd_valid)
					begin
						if (is_write)
							state <= ST_WDATA;
						else
							state <= is_sys ? ST_APB_SETUP : ST_AHB_REQ;
					end
				ST_WDATA:
					if (cmd_valid)
						state <= is_sys ? ST_APB_SETUP : ST_AHB_REQ;
				ST_AHB_REQ:
					state <= ST_AHB_WAIT;
				ST_AHB_WAIT:
					if (ahb.hready)
					begin
						status_q <= make_status(ahb.hresp, 1'b0);
						state    <= ST_RSP_STATUS;
					end
				ST_APB_SETUP:
					state <= ST_APB_ACCESS;
				ST_APB_ACCESS:
					if (apb.pready)
					begin
						status_q <= make_status(apb.pslverr, 1'b0);
						state    <= ST_RSP_STATUS;
					end
				ST_RSP_STATUS:
					if (rsp_ready)
						state <= is_write ? ST_IDLE : ST_RSP_DATA;
				ST_RSP_DATA:
					if (rsp_ready)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge rvx_port_22)
	begin
		if (cmd_valid && (state == ST_ADDR))
			addr_q <= cmd_data;
		if (cmd_valid && (state == ST_WDATA))
			wdata_q <= cmd_data;
		if (timed_out)
			rdata_q <= '0;
		else if ((state == ST_AHB_WAIT) && ahb.hready)
			rdata_q <= ahb.hrdata;
		else if ((state == ST_APB_ACCESS) && apb.pready)
			rdata_q <= apb.prdata;
	end

	// ****************************************
	// Outputs
	// ****************************************
	assign cmd_ready = (state == ST_IDLE) || (state == ST_ADDR) || (state == ST_WDATA);
	assign rsp_valid = (state == ST_RSP_STATUS) || (state == ST_RSP_DATA);
	assign rsp_data  = (state == ST_RSP_DATA) ? rdata_q : status_q;

	assign busy    = (state == ST_AHB_REQ) || (state == ST_AHB_WAIT) ||
	                 (state == ST_APB_SETUP) || (state == ST_APB_ACCESS);
	assign restart = bus_done;

	assign ahb.htrans = (state == ST_AHB_REQ) ? dbg_pkg::HTRANS_NONSEQ : dbg_pkg::HTRANS_IDLE;
	assign ahb.haddr  = addr_q;
	assign ahb.hwrite = is_write;
	assign ahb.hsize  = dbg_pkg::HSIZE_WORD;
	assign ahb.hwdata = wdata_q;

	assign apb.psel    = (state == ST_APB_SETUP) || (state == ST_APB_ACCESS);
	assign apb.penable = (state == ST_APB_ACCESS);
	assign apb.paddr   = addr_q;
	assign apb.pwrite  = is_write;
	assign apb.pwdata  = wdata_q;

	// Response word held while the consumer stalls
	a_rsp_stable: assert property (@(posedge rvx_port_22) disable iff (!rvx_port_00)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)));

	// Never both buses at once
	a_one_bus: assert property (@(posedge rvx_port_22) disable iff (!rvx_port_00)
		!(apb.psel && (ahb.htrans == dbg_pkg::HTRANS_NONSEQ)));

endmodule

`default_nettype wire

//--- src/dbg_timeout_counter.sv
// ****************************************
// Stall detector for one bus access
// expired is registered, one cycle after LIMIT busy cycles
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_timeout_counter
#(
	parameter int LIMIT = `DBG_TIMEOUT_CYCLES
)
(
	input  wire logic rvx_port_22,
	input  wire logic rvx_port_00,
	input  wire logic busy,
	input  wire logic restart,
	output logic      expired
);

	localparam int CNT_W = (LIMIT > 1) ? $clog2(LIMIT) : 1;

	logic [CNT_W-1:0] count;
	logic             at_limit;

	assign at_limit = (count == CNT_W'(LIMIT - 1));

	always_ff @(posedge rvx_port_22 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			count   <= '0;
			expired <= 1'b0;
		end
		else
		begin
			expired <= busy && !restart && at_limit;
			// Wraps after the limit so a stuck master gets repeated pulses
			if (!busy || restart || at_limit)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// Master must still be busy when the pulse arrives
	a_expired_busy: assert property (@(posedge rvx_port_22) disable iff (!rvx_port_00)
		expired |-> busy);

endmodule

`default_nettype wire

//--- src/dbg_ahb_sram.sv
// ****************************************
// Word SRAM on AHB-Lite, window from address 0
// Outside the window hready stays low until the next NONSEQ
// Assumes a single master that issues one transfer at a time
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_ahb_sram
(
	input  wire logic rvx_port_22,
	input  wire logic rvx_port_00,
	dbg_ahb_if.slave  bus
);

	localparam int IDX_W  = $clog2(`DBG_SRAM_WORDS);
	localparam int WAIT_W = (`DBG_SRAM_WAIT > 0) ? $clog2(`DBG_SRAM_WAIT + 1) : 1;

	logic [`DBG_DATA_W-1:0] mem [`DBG_SRAM_WORDS];

	logic              active;
	logic              in_win;
	logic              write_q;
	logic [IDX_W-1:0]  idx_q;
	logic [WAIT_W-1:0] wait_cnt;
	logic              addr_hit;
	logic              done;

	assign addr_hit = (bus.haddr[`DBG_ADDR_W-1:IDX_W+2] == '0);
	assign done     = active && in_win && (wait_cnt == WAIT_W'(`DBG_SRAM_WAIT));

	// Address phase capture and wait state count
	always_ff @(posedge rvx_port_22 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			active   <= 1'b0;
			in_win   <= 1'b0;
			write_q  <= 1'b0;
			idx_q    <= '0;
			wait_cnt <= '0;
		end
		else if (bus.htrans == dbg_pkg::HTRANS_NONSEQ)
		begin
			active   <= 1'b1;
			in_win   <= addr_hit;
			write_q  <= bus.hwrite;
			idx_q    <= bus.haddr[IDX_W+1:2];
			wait_cnt <= '0;
		end
		else if (done)
			active <= 1'b0;
		else if (active && in_win)
			wait_cnt <= wait_cnt + 1'b1;
	end

	// Write lands in the last data phase cycle
	always_ff @(posedge rvx_port_22)
	begin
		if (done && write_q)
			mem[idx_q] <= bus.hwdata;
	end

	assign bus.hrdata = mem[idx_q];
	assign bus.hready = !active || done;
	assign bus.hresp  = 1'b0;

	a_word_only: assert property (@(posedge rvx_port_22) disable iff (!rvx_port_00)
		(bus.htrans == dbg_pkg::HTRANS_NONSEQ) |-> (bus.hsize == dbg_pkg::HSIZE_WORD));

endmodule

`default_nettype wire

//--- src/dbg_sys_regs.sv
// ****************************************
// APB system registers, zero wait states
// Register 0 is the read-only ID, the rest reset to zero
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_sys_regs
(
	input  wire logic rvx_port_22,
	input  wire logic rvx_port_00,
	dbg_apb_if.slave  bus
);

	localparam int IDX_W = $clog2(`DBG_SYS_REGS);

	logic [`DBG_DATA_W-1:0] regs [`DBG_SYS_REGS];

	logic             in_range;
	logic [IDX_W-1:0] idx;
	logic             access;
	logic             bad;

	assign in_range = (bus.paddr[`DBG_ADDR_W-1:IDX_W+2] == '0);
	assign idx      = bus.paddr[IDX_W+1:2];
	assign access   = bus.psel && bus.penable;

	// Writes to the ID and anything past the last register are refused
	assign bad = !in_range || (bus.pwrite && (idx == '0));

	assign bus.pready  = access;
	assign bus.pslverr = access && bad;

	always_comb
	begin
		if (!in_range)
			bus.prdata = '0;
		else if (idx == '0)
			bus.prdata = `DBG_SYS_ID;
		else
			bus.prdata = regs[idx];
	end

	always_ff @(posedge rvx_port_22 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			for (int i = 0; i < `DBG_SYS_REGS; i++)
				regs[i] <= '0;
		end
		else if (access && bus.pwrite && !bad)
			regs[idx] <= bus.pwdata;
	end

	// Access phase only right after a setup phase
	a_apb_phase: assert property (@(posedge rvx_port_22) disable iff (!rvx_port_00)
		bus.penable |-> (bus.psel && $past(bus.psel && !bus.penable)));

endmodule

`default_nettype wire

//--- src/dbg_access_top.sv
// ****************************************
// Debug access port with its AHB SRAM and APB registers
// Command and response streams use valid and ready
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_access_top
(
	input  wire logic                   rvx_port_22,
	input  wire logic                   rvx_port_00,

	input  wire logic                   cmd_valid,
	input  wire logic [`DBG_DATA_W-1:0] cmd_data,
	output logic                        cmd_ready,

	output logic                        rsp_valid,
	output logic [`DBG_DATA_W-1:0]      rsp_data,
	input  wire logic                   rsp_ready
);

	logic busy;
	logic restart;
	logic expired;

	dbg_ahb_if ahb_bus ();
	dbg_apb_if apb_bus ();

	dbg_cmd_engine u_engine
	(
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00),
		.cmd_valid   (cmd_valid),
		.cmd_data    (cmd_data),
		.cmd_ready   (cmd_ready),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_ready   (rsp_ready),
		.busy        (busy),
		.restart     (restart),
		.expired     (expired),
		.ahb         (ahb_bus.master),
		.apb         (apb_bus.master)
	);

	dbg_timeout_counter #(
		.LIMIT (`DBG_TIMEOUT_CYCLES)
	) u_timeout (
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00),
		.busy        (busy),
		.restart     (restart),
		.expired     (expired)
	);

	dbg_ahb_sram u_sram
	(
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00),
		.bus         (ahb_bus.slave)
	);

	dbg_sys_regs u_sys_regs
	(
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00),
		.bus         (apb_bus.slave)
	);

endmodule

`default_nettype wire

//--- sim/dbg_clk_gen.sv
// ****************************************
// Testbench clock and active low reset
// Reset is released on a falling edge
// ****************************************
`default_nettype none

module dbg_clk_gen
#(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
)
(
	output logic rvx_port_22,
	output logic rvx_port_00
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		rvx_port_22 = 1'b0;
		forever
			#(PERIOD_NS / 2) rvx_port_22 = ~rvx_port_22;
	end

	initial
	begin
		rvx_port_00 = 1'b0;
		repeat (RESET_CYCLES) @(posedge rvx_port_22);
		@(negedge rvx_port_22);
		rvx_port_00 = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/dbg_access_tb.sv
// ****************************************
// Testbench of the debug access port
// Commands use word aligned addresses and codes 0 to 3 only
// Back-pressure on responses is random with a fixed seed
// ****************************************
`default_nettype none

`include "dbg_cfg.svh"

module dbg_access_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND          = 12;
	localparam int N_CMDS          = 31 + 2 * N_RAND;
	localparam int WATCHDOG_CYCLES = N_CMDS * (`DBG_TIMEOUT_CYCLES + 20) + 10;

	logic                   rvx_port_22;
	logic                   rvx_port_00;
	logic                   cmd_valid;
	logic [`DBG_DATA_W-1:0] cmd_data;
	logic                   cmd_ready;
	logic                   rsp_valid;
	logic [`DBG_DATA_W-1:0] rsp_data;
	logic                   rsp_ready;

	integer seed = 32'h905e;
	int     status_errs = 0;
	int     data_errs = 0;
	int     flag_errs = 0;
	int     proto_errs = 0;
	bit     all_sent = 1'b0;

	// Reference state and expected responses in order
	logic [`DBG_DATA_W-1:0] model_sram [`DBG_SRAM_WORDS];
	bit                     model_sram_set [`DBG_SRAM_WORDS];
	logic [`DBG_DATA_W-1:0] model_regs [`DBG_SYS_REGS];
	dbg_pkg::rsp_status_t   exp_status_q [$];
	logic [`DBG_DATA_W-1:0] exp_data_q [$];
	bit                     exp_read_q [$];
	bit                     exp_known_q [$];

	dbg_clk_gen #(.PERIOD_NS (40), .RESET_CYCLES (5)) u_clk
	(
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00)
	);

	dbg_access_top uut
	(
		.rvx_port_22 (rvx_port_22),
		.rvx_port_00 (rvx_port_00),
		.cmd_valid   (cmd_valid),
		.cmd_data    (cmd_data),
		.cmd_ready   (cmd_ready),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_ready   (rsp_ready)
	);

	// ****************************************
	// Reference model
	// ****************************************
	function automatic void model_access(input logic [`DBG_DATA_W-1:0] cmd_word,
		input logic [`DBG_ADDR_W-1:0] addr, input logic [`DBG_DATA_W-1:0] wdata,
		output dbg_pkg::rsp_status_t st, output logic [`DBG_DATA_W-1:0] data,
		output bit has_data, output bit known);
		logic [1:0]             code;
		logic [`DBG_ADDR_W-1:0] idx;
		code = (cmd_word[`DBG_DATA_W-1:2] == '0) ? cmd_word[1:0] : 2'd0;
		idx      = addr >> 2;
		st       = '0;
		data     = '0;
		has_data = !code[0];
		known    = 1'b1;
		if (!code[1])
		begin
			if (idx >= `DBG_SRAM_WORDS)
			begin
				// No slave answers, the timeout recovers the access
				st.error   = 1'b1;
				st.timeout = 1'b1;
			end
			else if (code[0])
			begin
				model_sram[idx]     = wdata;
				model_sram_set[idx] = 1'b1;
			end
			else
			begin
				data  = model_sram[idx];
				known = model_sram_set[idx];
			end
		end
		else if (idx >= `DBG_SYS_REGS)
		begin
			st.error = 1'b1;
			known    = 1'b0;
		end
		else if (code[0])
		begin
			if (idx == 0)
				st.error = 1'b1;
			else
				model_regs[idx] = wdata;
		end
		else
			data = (idx == 0) ? `DBG_SYS_ID : model_regs[idx];
	endfunction

	// ****************************************
	// Compare tasks
	// ****************************************
	task automatic check_status(input string name, input dbg_pkg::rsp_status_t exp,
		input dbg_pkg::rsp_status_t act);
		if (act !== exp)
		begin
			status_errs++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input logic [`DBG_DATA_W-1:0] exp,
		input logic [`DBG_DATA_W-1:0] act);
		if (act !== exp)
		begin
			data_errs++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			flag_errs++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// ****************************************
	// Stream drivers
	// ****************************************
	task automatic send_word(input logic [`DBG_DATA_W-1:0] word);
		@(negedge rvx_port_22);
		cmd_valid = 1'b1;
		cmd_data  = word;
		@(posedge rvx_port_22);
		while (!cmd_ready)
			@(posedge rvx_port_22);
	endtask

	task automatic run_cmd(input dbg_pkg::cmd_t code, input logic [`DBG_ADDR_W-1:0] addr,
		input logic [`DBG_DATA_W-1:0] wdata);
		logic [`DBG_DATA_W-1:0] cmd_word;
		dbg_pkg::rsp_status_t   st;
		logic [`DBG_DATA_W-1:0] data;
		bit                     has_data;
		bit                     known;
		cmd_word      = '0;
		cmd_word[1:0] = code;
		model_access(cmd_word, addr, wdata, st, data, has_data, known);
		exp_status_q.push_back(st);
		exp_data_q.push_back(data);
		exp_read_q.push_back(has_data);
		exp_known_q.push_back(known);
		send_word(cmd_word);
		send_word(addr);
		if ((code == dbg_pkg::MEM_WRITE) || (code == dbg_pkg::SYS_WRITE))
			send_word(wdata);
		@(negedge rvx_port_22);
		cmd_valid = 1'b0;
	endtask

	// Random stall before each word is accepted
	task automatic recv_word(output logic [`DBG_DATA_W-1:0] word);
		int stall;
		stall = $unsigned($random(seed)) % 4;
		@(negedge rvx_port_22);
		rsp_ready = 1'b0;
		repeat (stall) @(negedge rvx_port_22);
		rsp_ready = 1'b1;
		@(posedge rvx_port_22);
		while (!rsp_valid)
			@(posedge rvx_port_22);
		word = rsp_data;
		@(negedge rvx_port_22);
		rsp_ready = 1'b0;
	endtask

	task automatic collect_responses();
		logic [`DBG_DATA_W-1:0] word;
		dbg_pkg::rsp_status_t   exp_st;
		logic [`DBG_DATA_W-1:0] exp_d;
		bit                     rd;
		bit                     known;
		bit                     finished;
		finished = 1'b0;
		while (!finished)
		begin
			while ((exp_status_q.size() == 0) && !all_sent)
				@(negedge rvx_port_22);
			if (exp_status_q.size() == 0)
				finished = 1'b1;
			else
			begin
				exp_st = exp_status_q.pop_front();
				exp_d  = exp_data_q.pop_front();
				rd     = exp_read_q.pop_front();
				known  = exp_known_q.pop_front();
				recv_word(word);
				check_status("rsp_data status", exp_st, dbg_pkg::rsp_status_t'(word));
				if (rd)
				begin
					recv_word(word);
					if (known)
						check_data("rsp_data read data", exp_d, word);
				end
			end
		end
	endtask

	task automatic run_tests();
		int                     ridx [N_RAND];
		logic [`DBG_DATA_W-1:0] value;
		// Registers 1 to 7 come out of reset as zero
		for (int i = 1; i < `DBG_SYS_REGS; i++)
			run_cmd(dbg_pkg::SYS_READ, i * 4, '0);
		// ID register, then write and read back
		run_cmd(dbg_pkg::SYS_READ, 0, '0);
		for (int i = 1; i < `DBG_SYS_REGS; i++)
		begin
			value = $random(seed);
			run_cmd(dbg_pkg::SYS_WRITE, i * 4, value);
			run_cmd(dbg_pkg::SYS_READ, i * 4, '0);
		end
		// Refused system accesses
		run_cmd(dbg_pkg::SYS_WRITE, 0, 32'hDEAD_BEEF);
		run_cmd(dbg_pkg::SYS_READ, `DBG_SYS_REGS * 4, '0);
		run_cmd(dbg_pkg::SYS_WRITE, `DBG_SYS_REGS * 4 + 4, 32'h1234_5678);
		run_cmd(dbg_pkg::SYS_READ, 0, '0);
		// SRAM write and read, then random words across the window
		run_cmd(dbg_pkg::MEM_WRITE, 32'h10, 32'hA5A5_0F0F);
		run_cmd(dbg_pkg::MEM_READ, 32'h10, '0);
		for (int i = 0; i < N_RAND; i++)
		begin
			ridx[i] = $unsigned($random(seed)) % `DBG_SRAM_WORDS;
			value   = $random(seed);
			run_cmd(dbg_pkg::MEM_WRITE, ridx[i] * 4, value);
		end
		for (int i = 0; i < N_RAND; i++)
			run_cmd(dbg_pkg::MEM_READ, ridx[i] * 4, '0);
		// Outside the window, then a normal access
		run_cmd(dbg_pkg::MEM_READ, 32'h400, '0);
		run_cmd(dbg_pkg::MEM_WRITE, 32'h1000, 32'h5555_AAAA);
		run_cmd(dbg_pkg::MEM_READ, 32'h10, '0);
		all_sent = 1'b1;
	endtask

	// ****************************************
	// Stream protocol monitor
	// ****************************************
	logic                   held = 1'b0;
	logic [`DBG_DATA_W-1:0] held_data;

	always @(posedge rvx_port_22)
	begin
		if (rvx_port_00)
		begin
			if (rsp_valid && cmd_ready)
			begin
				proto_errs++;
				$display("At %0t ns cmd_ready was high while a response was pending", $time);
			end
			if (held && !rsp_valid)
			begin
				proto_errs++;
				$display("At %0t ns a stalled response word was withdrawn", $time);
			end
			else if (held && (rsp_data !== held_data))
			begin
				proto_errs++;
				$display("At %0t ns a stalled response word changed", $time);
			end
			held      = rsp_valid && !rsp_ready;
			held_data = rsp_data;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge rvx_port_22);
		$display("Watchdog expired, the DUT stopped answering");
		$display("tests failed");
		$finish;
	end

	initial
	begin
		cmd_valid = 1'b0;
		cmd_data  = '0;
		rsp_ready = 1'b0;
		// Model registers start from their reset value
		for (int i = 0; i < `DBG_SYS_REGS; i++)
			model_regs[i] = '0;
		wait (rvx_port_00);
		@(posedge rvx_port_22);
		check_flag("cmd_ready", 1'b1, cmd_ready);
		check_flag("rsp_valid", 1'b0, rsp_valid);
		fork
			run_tests();
			collect_responses();
		join
		repeat (4) @(posedge rvx_port_22);
		check_flag("rsp_valid", 1'b0, rsp_valid);
		check_flag("cmd_ready", 1'b1, cmd_ready);
		$display("Errors: status %0d, data %0d, flags %0d, protocol %0d",
			status_errs, data_errs, flag_errs, proto_errs);
		if ((status_errs + data_errs + flag_errs + proto_errs) == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/dbg_pkg.sv
src/dbg_ahb_if.sv
src/dbg_apb_if.sv
src/dbg_cmd_engine.sv
src/dbg_timeout_counter.sv
src/dbg_ahb_sram.sv
src/dbg_sys_regs.sv
src/dbg_access_top.sv
sim/dbg_clk_gen.sv
sim/dbg_access_tb.sv
